// File: dma_burst_addr_gen.sv
//**************************************************************************
// Walks the lines of a fill transfer and issues AW bursts.
// Holds with awvalid low while the data side queue is full.
// cfg must stay stable from start until done.
//**************************************************************************

module dma_burst_addr_gen
	import dma_fill_pkg::*;
#(
	parameter int ADDR_W = 32
)
(
	input  logic              rvx_port_00,
	input  logic              rvx_port_14,
	input  dma_cfg_t          cfg,
	input  logic              start,
	input  logic              queue_full,
	input  logic              awready,
	output logic [ADDR_W-1:0] awaddr,
	output logic [LEN_W-1:0]  awlen,
	output logic              awvalid,
	output burst_cmd_t        aw_cmd
);

	localparam int FULL_BURST_BYTES = (MAX_BURST_LEN + 1) * STRB_W;

	addr_state_e state;
	addr_state_e st_first;
	addr_state_e st_after_full;
	addr_state_e st_after_words;
	addr_state_e st_after_bytes;

	logic [ADDR_W-1:0]      line_base;
	logic [ADDR_W-1:0]      next_base;
	logic [15:0]            line_cnt;
	logic [LINE_SIZE_W-1:0] byte_cnt;
	logic [LINE_SIZE_W-1:0] full_part;
	logic                   last_line;
	logic                   full_last;
	logic                   issuing;
	logic                   aw_hs;
	logic                   final_burst;
	logic [STRB_W-1:0]      strb;

	//**********************************************************************
	// Burst sequencing decisions
	//**********************************************************************

	// Full part of the line in bytes, low six bits are always zero
	assign full_part = {cfg.line_size.full_bursts, 6'd0};
	assign full_last = (byte_cnt == full_part);
	assign last_line = (line_cnt == cfg.num_lines);

	// First line starts at start_addr, the rest step by stride
	assign next_base = (line_cnt == 16'd0) ? ADDR_W'(cfg.start_addr)
		: line_base + ADDR_W'(cfg.stride);

	always_comb
	begin
		st_after_bytes = last_line ? IDLE : LINE_SETUP;

		if (cfg.line_size.rem_bytes != 2'd0)
			st_after_words = REM_BYTES;
		else
			st_after_words = st_after_bytes;

		if (cfg.line_size.rem_beats != '0)
			st_after_full = REM_BEATS;
		else
			st_after_full = st_after_words;

		// First non-empty kind of burst in a line
		if (cfg.line_size.full_bursts != '0)
			st_first = FULL_BURST;
		else if (cfg.line_size.rem_beats != '0)
			st_first = REM_BEATS;
		else
			st_first = REM_BYTES;
	end

	//**********************************************************************
	// AW channel
	//**********************************************************************

	assign issuing = (state == FULL_BURST) || (state == REM_BEATS) || (state == REM_BYTES);
	assign awvalid = issuing && !queue_full;
	assign aw_hs = awvalid && awready;

	always_comb
	begin
		case (state)
			FULL_BURST:
			begin
				awlen = LEN_W'(MAX_BURST_LEN);
				strb = '1;
				final_burst = full_last && (st_after_full == IDLE);
			end
			REM_BEATS:
			begin
				awlen = cfg.line_size.rem_beats - 1'b1;
				strb = '1;
				final_burst = (st_after_words == IDLE);
			end
			REM_BYTES:
			begin
				// Single beat, only the low rem_bytes lanes written
				awlen = '0;
				strb = STRB_W'((1 << cfg.line_size.rem_bytes) - 1);
				final_burst = (st_after_bytes == IDLE);
			end
			default:
			begin
				awlen = '0;
				strb = '0;
				final_burst = 1'b0;
			end
		endcase
	end

	assign aw_cmd = '{len: awlen, wstrb: strb, last_of_xfer: final_burst};

	//**********************************************************************
	// State machine
	//**********************************************************************

	always_ff @(posedge rvx_port_00 or negedge rvx_port_14)
	begin
		if (!rvx_port_14)
		begin
			state <= IDLE;
			line_cnt <= '0;
		end
		else
		begin
			case (state)
				IDLE:
				begin
					if (start)
					begin
						line_cnt <= '0;
						state <= LINE_SETUP;
					end
				end
				LINE_SETUP:
				begin
					line_cnt <= line_cnt + 16'd1;
					state <= st_first;
				end
				FULL_BURST:
				begin
					if (aw_hs && full_last)
						state <= st_after_full;
				end
				REM_BEATS:
				begin
					if (aw_hs)
						state <= st_after_words;
				end
				REM_BYTES:
				begin
					if (aw_hs)
						state <= st_after_bytes;
				end
				default:
				begin
					state <= IDLE;
				end
			endcase
		end
	end

	// Address and byte count, loaded at each line setup
	always_ff @(posedge rvx_port_00)
	begin
		if (state == LINE_SETUP)
		begin
			line_base <= next_base;
			awaddr <= next_base;
			byte_cnt <= LINE_SIZE_W'(FULL_BURST_BYTES);
		end
		else if (aw_hs && (state == FULL_BURST))
		begin
			awaddr <= awaddr + ADDR_W'(FULL_BURST_BYTES);
			byte_cnt <= byte_cnt + LINE_SIZE_W'(FULL_BURST_BYTES);
		end
		else if (aw_hs && (state == REM_BEATS))
		begin
			awaddr <= awaddr + ADDR_W'(cfg.line_size.rem_beats) * ADDR_W'(STRB_W);
		end
	end

endmodule

// File: dma_fill_pkg.sv
//**************************************************************************
// Shared types for the 2D fill DMA write path.
// Config fields are fixed at 32 bits and match the default ADDR_W/DATA_W.
// Start addresses are word aligned and line_size is never zero.
//**************************************************************************

package dma_fill_pkg;

	//**********************************************************************
	// Burst constants
	//**********************************************************************

	// AXI length field of a full burst (16 beats)
	localparam int MAX_BURST_LEN = 15;
	localparam int LEN_W = 4;
	localparam int LINE_SIZE_W = 16;
	// Byte lanes of the 32-bit data bus
	localparam int STRB_W = 4;

	//**********************************************************************
	// Structs and enums
	//**********************************************************************

	// Same bit pattern as the plain byte count of a line
	typedef struct packed {
		logic [LINE_SIZE_W-7:0] full_bursts;
		logic [LEN_W-1:0]       rem_beats;
		logic [1:0]             rem_bytes;
	} line_size_t;

	typedef struct packed {
		logic [31:0] start_addr;
		line_size_t  line_size;
		logic [15:0] num_lines;
		logic [31:0] stride;
		logic [31:0] fill_seed;
	} dma_cfg_t;

	// One issued burst as seen by the data side
	typedef struct packed {
		logic [LEN_W-1:0]  len;
		logic [STRB_W-1:0] wstrb;
		logic              last_of_xfer;
	} burst_cmd_t;

	typedef enum logic [2:0] {
		IDLE,
		LINE_SETUP,
		FULL_BURST,
		REM_BEATS,
		REM_BYTES
	} addr_state_e;

endpackage

// File: dma_fill_top.sv
//**************************************************************************
// Write side of the 2D fill DMA, AW and W channels only.
// No B channel; the transfer ends at the last W handshake.
//**************************************************************************

module dma_fill_top
	import dma_fill_pkg::*;
#(
	parameter int ADDR_W = 32,
	parameter int DATA_W = 32
)
(
	input  logic                rvx_port_00,
	input  logic                rvx_port_14,
	input  dma_cfg_t            cfg,
	input  logic                start,
	output logic                done,
	output logic [ADDR_W-1:0]   awaddr,
	output logic [LEN_W-1:0]    awlen,
	output logic                awvalid,
	input  logic                awready,
	output logic [DATA_W-1:0]   wdata,
	output logic [DATA_W/8-1:0] wstrb,
	output logic                wlast,
	output logic                wvalid,
	input  logic                wready
);

	burst_cmd_t aw_cmd;
	logic       queue_full;

	// Address side
	dma_burst_addr_gen #(
		.ADDR_W(ADDR_W)
	) u_addr_gen (
		.rvx_port_00(rvx_port_00),
		.rvx_port_14(rvx_port_14),
		.cfg        (cfg),
		.start      (start),
		.queue_full (queue_full),
		.awready    (awready),
		.awaddr     (awaddr),
		.awlen      (awlen),
		.awvalid    (awvalid),
		.aw_cmd     (aw_cmd)
	);

	// Data side, fed by every AW handshake
	dma_fill_wdata_gen #(
		.DATA_W(DATA_W)
	) u_wdata_gen (
		.rvx_port_00(rvx_port_00),
		.rvx_port_14(rvx_port_14),
		.cfg        (cfg),
		.start      (start),
		.aw_cmd     (aw_cmd),
		.awvalid    (awvalid),
		.awready    (awready),
		.wready     (wready),
		.queue_full (queue_full),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wlast      (wlast),
		.wvalid     (wvalid),
		.done       (done)
	);

endmodule

// File: dma_fill_wdata_gen.sv
//**************************************************************************
// Pattern write beats for the bursts issued on AW.
// Two-entry burst queue; wdata is fill_seed plus a beat index that start clears.
//**************************************************************************

module dma_fill_wdata_gen
	import dma_fill_pkg::*;
#(
	parameter int DATA_W = 32
)
(
	input  logic                rvx_port_00,
	input  logic                rvx_port_14,
	input  dma_cfg_t            cfg,
	input  logic                start,
	input  burst_cmd_t          aw_cmd,
	input  logic                awvalid,
	input  logic                awready,
	input  logic                wready,
	output logic                queue_full,
	output logic [DATA_W-1:0]   wdata,
	output logic [DATA_W/8-1:0] wstrb,
	output logic                wlast,
	output logic                wvalid,
	output logic                done
);

	localparam int WSTRB_W = DATA_W / 8;

	burst_cmd_t        q_mem [2];
	burst_cmd_t        head;
	logic              wr_ptr;
	logic              rd_ptr;
	logic [1:0]        q_count;
	logic [LEN_W-1:0]  beat_cnt;
	logic [DATA_W-1:0] beat_idx;
	logic              push;
	logic              pop;
	logic              w_hs;

	assign push = awvalid && awready;
	assign head = q_mem[rd_ptr];
	assign queue_full = (q_count == 2'd2);

	// Beats always come from the queue head
	assign wvalid = (q_count != 2'd0);
	assign wlast = wvalid && (beat_cnt == head.len);
	assign wstrb = WSTRB_W'(head.wstrb);
	assign wdata = DATA_W'(cfg.fill_seed) + beat_idx;
	assign w_hs = wvalid && wready;
	assign pop = w_hs && wlast;

	always_ff @(posedge rvx_port_00)
	begin
		if (push)
			q_mem[wr_ptr] <= aw_cmd;
	end

	always_ff @(posedge rvx_port_00 or negedge rvx_port_14)
	begin
		if (!rvx_port_14)
		begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			q_count <= '0;
			beat_cnt <= '0;
			beat_idx <= '0;
			done <= 1'b0;
		end
		else
		begin
			// One cycle after the closing wlast handshake
			done <= pop && head.last_of_xfer;

			if (push)
				wr_ptr <= ~wr_ptr;
			if (pop)
				rd_ptr <= ~rd_ptr;

			if (push && !pop)
				q_count <= q_count + 2'd1;
			else if (pop && !push)
				q_count <= q_count - 2'd1;

			if (pop)
				beat_cnt <= '0;
			else if (w_hs)
				beat_cnt <= beat_cnt + 1'b1;

			if (start)
				beat_idx <= '0;
			else if (w_hs)
				beat_idx <= beat_idx + 1'b1;
		end
	end

endmodule

// File: filelist.f
dma_fill_pkg.sv
dma_burst_addr_gen.sv
dma_fill_wdata_gen.sv
dma_fill_top.sv
tb_dma_fill.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the fill DMA testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -Wno-fatal --top-module tb_dma_fill \
	-f filelist.f -o sim_tb_dma_fill

./obj_dir/sim_tb_dma_fill | tee "$LOG"

if grep -q "RESULT: FAIL" "$LOG"; then
	echo "simulation failed, see $LOG"
	exit 1
fi

if ! grep -q "RESULT: PASS" "$LOG"; then
	echo "simulation ended without a result, see $LOG"
	exit 1
fi

// File: tb_dma_fill.sv
//**************************************************************************
// Directed testbench for the fill DMA write side.
// Expected bursts and beats come from the line split rule of the DMA.
// Inputs change on the rising edge and outputs are sampled on the falling edge.
//**************************************************************************

module tb_dma_fill
	import dma_fill_pkg::*;
();

	// Beats of all tests; four cycles per beat covers random ready
	localparam int TOTAL_BEATS = 32 + 19 + 18 + 30 + 18;
	localparam int CYCLE_LIMIT = TOTAL_BEATS * 4 + 400;

	typedef struct packed {
		logic [31:0] addr;
		logic [3:0]  len;
	} aw_beat_t;

	typedef struct packed {
		logic [31:0] data;
		logic [3:0]  strb;
		logic        last;
	} w_beat_t;

	logic        rvx_port_00;
	logic        rvx_port_14;
	dma_cfg_t    cfg;
	logic        start;
	logic        done;
	logic [31:0] awaddr;
	logic [3:0]  awlen;
	logic        awvalid;
	logic        awready;
	logic [31:0] wdata;
	logic [3:0]  wstrb;
	logic        wlast;
	logic        wvalid;
	logic        wready;

	aw_beat_t exp_aw[$];
	w_beat_t  exp_w[$];
	aw_beat_t aw_exp;
	w_beat_t  w_exp;
	int       err_cnt;
	int       done_cnt;
	int       tests_run;
	int       tests_failed;
	int       cycle_cnt;
	int       seed;

	dma_fill_top #(
		.ADDR_W(32),
		.DATA_W(32)
	) u_dma_fill_top (
		.rvx_port_00(rvx_port_00),
		.rvx_port_14(rvx_port_14),
		.cfg        (cfg),
		.start      (start),
		.done       (done),
		.awaddr     (awaddr),
		.awlen      (awlen),
		.awvalid    (awvalid),
		.awready    (awready),
		.wdata      (wdata),
		.wstrb      (wstrb),
		.wlast      (wlast),
		.wvalid     (wvalid),
		.wready     (wready)
	);

	initial
	begin
		rvx_port_00 = 1'b0;
		forever #50 rvx_port_00 = ~rvx_port_00;
	end

	task automatic check_value(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("error: time %0t, %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			err_cnt++;
		end
	endtask

	//**********************************************************************
	// Reference model of the line split into full, word and byte bursts
	//**********************************************************************

	task automatic build_expected(input dma_cfg_t c);
		int          size;
		int          nfull;
		int          words;
		int          bytes;
		logic [31:0] addr;
		logic [31:0] beat;
		logic [3:0]  byte_strb;
		beat = 32'd0;
		size = int'({16'd0, c.line_size});
		nfull = size / 64;
		words = (size % 64) / 4;
		bytes = size % 4;
		for (int ln = 0; ln < int'(c.num_lines); ln++)
		begin
			addr = c.start_addr + 32'(ln) * c.stride;
			for (int i = 0; i < nfull; i++)
			begin
				exp_aw.push_back('{addr: addr, len: 4'd15});
				for (int b = 0; b < 16; b++)
				begin
					exp_w.push_back('{data: c.fill_seed + beat, strb: 4'hf, last: (b == 15)});
					beat++;
				end
				addr = addr + 32'd64;
			end
			if (words != 0)
			begin
				exp_aw.push_back('{addr: addr, len: 4'(words - 1)});
				for (int b = 0; b < words; b++)
				begin
					exp_w.push_back('{data: c.fill_seed + beat, strb: 4'hf,
						last: (b == words - 1)});
					beat++;
				end
				addr = addr + 32'(words * 4);
			end
			if (bytes != 0)
			begin
				// One lane per remaining byte, from lane 0 up
				byte_strb = 4'h0;
				for (int k = 0; k < bytes; k++)
					byte_strb[k] = 1'b1;
				exp_aw.push_back('{addr: addr, len: 4'd0});
				exp_w.push_back('{data: c.fill_seed + beat, strb: byte_strb,
					last: 1'b1});
				beat++;
			end
		end
	endtask

	// Handshakes seen here will complete on the next rising edge
	always @(negedge rvx_port_00)
	begin
		if (rvx_port_14)
		begin
			if (awvalid && awready)
			begin
				if (exp_aw.size() == 0)
				begin
					$display("AW burst at 0x%0h was not expected, time %0t", awaddr, $time);
					err_cnt++;
				end
				else
				begin
					aw_exp = exp_aw.pop_front();
					check_value("awaddr", awaddr, aw_exp.addr);
					check_value("awlen", 32'(awlen), 32'(aw_exp.len));
				end
			end
			if (wvalid && wready)
			begin
				if (exp_w.size() == 0)
				begin
					$display("W beat 0x%0h was not expected, time %0t", wdata, $time);
					err_cnt++;
				end
				else
				begin
					w_exp = exp_w.pop_front();
					check_value("wdata", wdata, w_exp.data);
					check_value("wstrb", 32'(wstrb), 32'(w_exp.strb));
					check_value("wlast", 32'(wlast), 32'(w_exp.last));
				end
			end
			if (done)
				done_cnt++;
		end
	end

	always @(posedge rvx_port_00)
	begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt == CYCLE_LIMIT)
		begin
			$display("timeout: done never came within %0d cycles", CYCLE_LIMIT);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic dma_cfg_t make_cfg(input logic [31:0] addr, input logic [15:0] size,
		input logic [15:0] lines, input logic [31:0] stride, input logic [31:0] fill);
		dma_cfg_t c;
		c.start_addr = addr;
		c.line_size = line_size_t'(size);
		c.num_lines = lines;
		c.stride = stride;
		c.fill_seed = fill;
		return c;
	endfunction

	task automatic report(input string name, input int errs_before);
		tests_run++;
		if (err_cnt == errs_before)
			$display("test %s passed", name);
		else
		begin
			tests_failed++;
			$display("test %s failed with %0d errors", name, err_cnt - errs_before);
		end
	endtask

	//**********************************************************************
	// Tests
	//**********************************************************************

	task automatic run_transfer(input string name, input dma_cfg_t c, input bit rand_ready);
		int errs_before;
		int done_before;
		int r;
		errs_before = err_cnt;
		done_before = done_cnt;
		build_expected(c);
		@(posedge rvx_port_00);
		cfg <= c;
		start <= 1'b1;
		awready <= 1'b1;
		wready <= 1'b1;
		@(posedge rvx_port_00);
		start <= 1'b0;
		while (done_cnt == done_before)
		begin
			@(posedge rvx_port_00);
			if (rand_ready)
			begin
				r = $random(seed);
				awready <= r[0];
				wready <= r[1];
			end
		end
		awready <= 1'b1;
		wready <= 1'b1;
		repeat (4) @(posedge rvx_port_00);
		check_value("done count", 32'(done_cnt - done_before), 32'd1);
		if (exp_aw.size() != 0 || exp_w.size() != 0)
		begin
			$display("%0d AW bursts and %0d W beats never arrived", exp_aw.size(), exp_w.size());
			err_cnt++;
			exp_aw.delete();
			exp_w.delete();
		end
		report(name, errs_before);
	endtask

	task automatic idle_after_reset();
		int errs_before;
		errs_before = err_cnt;
		repeat (20)
		begin
			@(negedge rvx_port_00);
			check_value("awvalid", 32'(awvalid), 32'd0);
			check_value("wvalid", 32'(wvalid), 32'd0);
			check_value("done", 32'(done), 32'd0);
		end
		report("idle_after_reset", errs_before);
	endtask

	initial
	begin
		seed = 32'h7ecb_830d;
		rvx_port_14 <= 1'b0;
		cfg <= '0;
		start <= 1'b0;
		awready <= 1'b0;
		wready <= 1'b0;
		repeat (10) @(posedge rvx_port_00);
		rvx_port_14 <= 1'b1;
		awready <= 1'b1;
		wready <= 1'b1;

		idle_after_reset();
		run_transfer("line_128", make_cfg(32'h0000_1000, 16'd128, 16'd1, 32'd0,
			32'h1000_0000), 1'b0);
		run_transfer("line_76", make_cfg(32'h0000_2000, 16'd76, 16'd1, 32'd0,
			32'ha5a5_0000), 1'b0);
		run_transfer("line_71", make_cfg(32'h0000_3000, 16'd71, 16'd1, 32'd0,
			32'h0000_0100), 1'b0);
		run_transfer("three_lines_40", make_cfg(32'h0000_4000, 16'd40, 16'd3, 32'd256,
			32'h5000_0000), 1'b0);
		// Same split as line_71, now under random back-pressure
		run_transfer("line_71_backpressure", make_cfg(32'h0000_3000, 16'd71, 16'd1, 32'd0,
			32'h0000_0100), 1'b1);

		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, err_cnt);
		if (err_cnt == 0)
			$display("RESULT: PASS");
		else
			$display("RESULT: FAIL");
		$finish;
	end

endmodule
